// ==== Makefile ====
# Verilator build and run of the FFT stage testbench
TOP := tb_fft_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

# pass only if the simulation prints the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

// ==== compile.f ====
hw/fft_pkg.sv
hw/complex_multiplier.sv
hw/twiddle_rom.sv
hw/credit_fifo.sv
hw/credit_receiver.sv
hw/iterative_butterfly.sv
hw/credit_sender.sv
hw/fft_stage_top.sv
testbench/fft_stage_checker.sv
testbench/tb_fft_stage.sv

// ==== hw/complex_multiplier.sv ====
// purely combinational; products are truncated toward minus infinity, no rounding or saturation
module complex_multiplier (
  input  fft_pkg::cplx_t x,
  input  fft_pkg::cplx_t y,
  output fft_pkg::cplx_t p
);
  import fft_pkg::*;

  // full precision partial products
  logic signed [2*WIDTH-1:0] prod_rr;
  logic signed [2*WIDTH-1:0] prod_ii;
  logic signed [2*WIDTH-1:0] prod_ri;
  logic signed [2*WIDTH-1:0] prod_ir;

  // one guard bit so the sums cannot overflow before the shift
  logic signed [2*WIDTH:0] sum_re;
  logic signed [2*WIDTH:0] sum_im;

  assign prod_rr = $signed(x.re) * $signed(y.re);
  assign prod_ii = $signed(x.im) * $signed(y.im);
  assign prod_ri = $signed(x.re) * $signed(y.im);
  assign prod_ir = $signed(x.im) * $signed(y.re);

  // (xr + j xi)(yr + j yi)
  assign sum_re = prod_rr - prod_ii;
  assign sum_im = prod_ri + prod_ir;

  // arithmetic shift by FRAC then keep the low WIDTH bits,
  // which is the same as taking this slice
  assign p.re = sum_re[FRAC +: WIDTH];
  assign p.im = sum_im[FRAC +: WIDTH];

endmodule

// ==== hw/credit_fifo.sv ====
// no back-pressure on push; the sender must hold credits, and pop while empty is not allowed
module credit_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH  = 2
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  push,
  input  item_t din,
  input  logic  pop,
  output item_t dout,
  output logic  empty,
  output logic  full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // storage, payload only
  item_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  assign empty = (count == '0);
  assign full  = (count == (PTR_W + 1)'(DEPTH));

  // head of queue is visible without a read cycle
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers wrap at DEPTH, so any depth works
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // a push into a full queue means the credit contract upstream was broken
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    !(push && full && !pop))
    else $error("credit_fifo overflow, push while full");

endmodule

// ==== hw/credit_receiver.sv ====
// upstream must start with IN_DEPTH credits and never send without one; no ready is given back
module credit_receiver (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  fft_pkg::batch_in_t in_data,
  output logic               in_credit,
  output logic               pair_valid,
  output fft_pkg::batch_in_t pair_batch,
  input  logic               pair_ready
);
  import fft_pkg::*;

  logic fifo_empty;
  logic pop;

  // a batch leaves on the valid/ready handshake
  assign pop = pair_valid && pair_ready;

  // every batch is pushed, the credits reserve its slot
  credit_fifo #(
    .item_t(batch_in_t),
    .DEPTH (IN_DEPTH)
  ) u_in_fifo (
    .clk  (clk),
    .reset(reset),
    .push (in_valid),
    .din  (in_data),
    .pop  (pop),
    .dout (pair_batch),
    .empty(fifo_empty),
    .full ()
  );

  // count is registered, so a push shows here one cycle later
  assign pair_valid = !fifo_empty;

  // one credit pulse the cycle after each pop
  always_ff @(posedge clk) begin
    if (reset) begin
      in_credit <= 1'b0;
    end else begin
      in_credit <= pop;
    end
  end

endmodule

// ==== hw/credit_sender.sv ====
// downstream must return credits one pulse at a time and no more than OUT_DEPTH + 2 outstanding
module credit_sender (
  input  logic                clk,
  input  logic                reset,
  input  logic                res_valid,
  input  fft_pkg::batch_out_t res_batch,
  output logic                res_ready,
  output logic                out_valid,
  output fft_pkg::batch_out_t out_data,
  input  logic                out_credit
);
  import fft_pkg::*;

  logic            fifo_empty;
  logic            fifo_full;
  logic            send;
  batch_out_t      head;
  logic [CRED_W-1:0] credits;

  assign res_ready = !fifo_full;

  // launch only with a credit in hand and data queued
  assign send = (credits != '0) && !fifo_empty;

  credit_fifo #(
    .item_t(batch_out_t),
    .DEPTH (OUT_DEPTH)
  ) u_out_fifo (
    .clk  (clk),
    .reset(reset),
    .push (res_valid && res_ready),
    .din  (res_batch),
    .pop  (send),
    .dout (head),
    .empty(fifo_empty),
    .full (fifo_full)
  );

  // credit counter, +1 per returned pulse, -1 per launch
  always_ff @(posedge clk) begin
    if (reset) begin
      credits   <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= send;
      if (out_credit && !send) begin
        credits <= credits + 1'b1;
      end else if (send && !out_credit) begin
        credits <= credits - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      out_data <= head;
    end
  end

  // each output beat was paid for by a credit held the cycle before
  a_paid_send: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> ($past(credits) != '0))
    else $error("out_valid without a downstream credit");

endmodule

// ==== hw/fft_pkg.sv ====
// Q2.14 fixed point throughout; products truncate, sums wrap, twiddles cover an 8-point FFT only
package fft_pkg;

  // ========================================
  // widths, depths and number format
  // ========================================
  localparam int WIDTH = 16;
  localparam int FRAC = 14;
  localparam int BATCH = 4;
  localparam int IN_DEPTH = 4;
  localparam int OUT_DEPTH = 2;

  // pair index inside a batch
  localparam int IDX_W = $clog2(BATCH);
  // sender credit counter, holds up to OUT_DEPTH + 2
  localparam int CRED_W = $clog2(OUT_DEPTH + 3);

  // twiddle constants, 1.0 and sqrt(2)/2 in Q2.14
  localparam logic signed [WIDTH-1:0] TW_ONE = 16'sd16384;
  localparam logic signed [WIDTH-1:0] TW_HALF = 16'sd11585;

  // ========================================
  // payload types
  // ========================================
  typedef struct packed {
    logic signed [WIDTH-1:0] re;
    logic signed [WIDTH-1:0] im;
  } cplx_t;

  // one butterfly job, k selects w = e^(-2*pi*i*k/8)
  typedef struct packed {
    cplx_t      a;
    cplx_t      b;
    logic [1:0] k;
  } bfly_pair_t;

  // c = a + w*b, d = a - w*b
  typedef struct packed {
    cplx_t c;
    cplx_t d;
  } bfly_result_t;

  typedef bfly_pair_t [BATCH-1:0] batch_in_t;
  typedef bfly_result_t [BATCH-1:0] batch_out_t;

endpackage

// ==== hw/fft_stage_top.sv ====
// one radix-2 stage of an 8-point FFT; latency is at least BATCH + 3 and grows under back-pressure
module fft_stage_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  input  fft_pkg::batch_in_t  in_data,
  output logic                in_credit,
  output logic                out_valid,
  output fft_pkg::batch_out_t out_data,
  input  logic                out_credit
);
  import fft_pkg::*;

  // receiver to butterfly
  logic       pair_valid;
  logic       pair_ready;
  batch_in_t  pair_batch;

  // butterfly to sender
  logic       res_valid;
  logic       res_ready;
  batch_out_t res_batch;

  credit_receiver u_rx (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_credit (in_credit),
    .pair_valid(pair_valid),
    .pair_batch(pair_batch),
    .pair_ready(pair_ready)
  );

  iterative_butterfly u_bfly (
    .clk       (clk),
    .reset     (reset),
    .pair_valid(pair_valid),
    .pair_batch(pair_batch),
    .pair_ready(pair_ready),
    .res_valid (res_valid),
    .res_batch (res_batch),
    .res_ready (res_ready)
  );

  credit_sender u_tx (
    .clk       (clk),
    .reset     (reset),
    .res_valid (res_valid),
    .res_batch (res_batch),
    .res_ready (res_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_credit(out_credit)
  );

endmodule

// ==== hw/iterative_butterfly.sv ====
// one shared multiplier, so a batch takes BATCH cycles; no new batch is taken until results leave
module iterative_butterfly (
  input  logic                clk,
  input  logic                reset,
  input  logic                pair_valid,
  input  fft_pkg::batch_in_t  pair_batch,
  output logic                pair_ready,
  output logic                res_valid,
  output fft_pkg::batch_out_t res_batch,
  input  logic                res_ready
);
  import fft_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    COMP,
    DONE
  } state_t;

  state_t state;
  logic [IDX_W-1:0] idx;

  // captured batch and results being built
  batch_in_t  in_reg;
  batch_out_t res_reg;

  // datapath for the pair at idx
  bfly_pair_t   cur;
  cplx_t        w;
  cplx_t        prod;
  bfly_result_t step;

  assign pair_ready = (state == IDLE);
  assign res_valid  = (state == DONE);
  assign res_batch  = res_reg;

  assign cur = in_reg[idx];

  twiddle_rom u_rom (
    .k(cur.k),
    .w(w)
  );

  // prod = w * b
  complex_multiplier u_mult (
    .x(cur.b),
    .y(w),
    .p(prod)
  );

  // sums wrap at WIDTH bits
  always_comb begin
    step.c.re = cur.a.re + prod.re;
    step.c.im = cur.a.im + prod.im;
    step.d.re = cur.a.re - prod.re;
    step.d.im = cur.a.im - prod.im;
  end

  // ========================================
  // batch FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      idx   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (pair_valid) begin
            state <= COMP;
            idx   <= '0;
          end
        end
        COMP: begin
          // one pair per cycle in index order
          if (idx == IDX_W'(BATCH - 1)) begin
            state <= DONE;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        default: begin
          // DONE waits for the sender
          if (res_ready) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (state == IDLE && pair_valid) begin
      in_reg <= pair_batch;
    end
    if (state == COMP) begin
      res_reg[idx] <= step;
    end
  end

  a_idx_range: assert property (@(posedge clk) disable iff (reset)
    (state == COMP) |-> (int'(idx) < BATCH))
    else $error("butterfly index out of range in COMP");

endmodule

// ==== hw/twiddle_rom.sv ====
// fixed table for the four twiddles of an 8-point FFT, other sizes need a new table
module twiddle_rom (
  input  logic [1:0]     k,
  output fft_pkg::cplx_t w
);
  import fft_pkg::*;

  // w = e^(-2*pi*i*k/8)
  always_comb begin
    case (k)
      2'd0: begin
        w.re = TW_ONE;
        w.im = '0;
      end
      2'd1: begin
        w.re = TW_HALF;
        w.im = -TW_HALF;
      end
      2'd2: begin
        w.re = '0;
        w.im = -TW_ONE;
      end
      default: begin
        // k = 3
        w.re = -TW_HALF;
        w.im = -TW_HALF;
      end
    endcase
  end

endmodule

// ==== testbench/fft_stage_checker.sv ====
// expects the in_valid beats in send order; totals are compared only once totals_req is raised
module fft_stage_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  input  fft_pkg::batch_in_t  in_data,
  input  logic                in_credit,
  input  logic                out_valid,
  input  fft_pkg::batch_out_t out_data,
  input  logic                out_credit,
  input  logic                totals_req,
  output int                  errors,
  output int                  in_count,
  output int                  out_count,
  output logic                totals_done
);
  import fft_pkg::*;

  // batches sent but not yet seen at the output, oldest first
  batch_in_t pending [$];

  int err_cnt = 0;
  int in_cnt = 0;
  int out_cnt = 0;
  int credit_pulses = 0;
  // downstream credits granted and not yet spent
  int granted = 0;
  logic done_flag = 1'b0;

  assign errors      = err_cnt;
  assign in_count    = in_cnt;
  assign out_count   = out_cnt;
  assign totals_done = done_flag;

  // reference butterfly, w from the 8-point twiddle table
  function automatic bfly_result_t expect_pair(input bfly_pair_t p);
    longint wr;
    longint wi;
    longint pr;
    longint pi;
    bfly_result_t r;
    case (p.k)
      2'd0: begin
        wr = 64'sd1 <<< FRAC;
        wi = 0;
      end
      2'd1: begin
        wr = longint'(TW_HALF);
        wi = -longint'(TW_HALF);
      end
      2'd2: begin
        wr = 0;
        wi = -(64'sd1 <<< FRAC);
      end
      default: begin
        wr = -longint'(TW_HALF);
        wi = -longint'(TW_HALF);
      end
    endcase
    // floor of the full product, then keep WIDTH bits through the sum
    pr = (longint'(p.b.re) * wr - longint'(p.b.im) * wi) >>> FRAC;
    pi = (longint'(p.b.re) * wi + longint'(p.b.im) * wr) >>> FRAC;
    r.c.re = WIDTH'(longint'(p.a.re) + pr);
    r.c.im = WIDTH'(longint'(p.a.im) + pi);
    r.d.re = WIDTH'(longint'(p.a.re) - pr);
    r.d.im = WIDTH'(longint'(p.a.im) - pi);
    return r;
  endfunction

  task automatic compare_batch(input batch_in_t src, input batch_out_t got);
    bfly_result_t exp_r;
    for (int i = 0; i < BATCH; i++) begin
      exp_r = expect_pair(src[i]);
      if (got[i].c !== exp_r.c) begin
        $display("CHECK FAILED out_data[%0d].c batch %0d expected %h got %h",
                 i, out_cnt, exp_r.c, got[i].c);
        err_cnt++;
      end
      if (got[i].d !== exp_r.d) begin
        $display("CHECK FAILED out_data[%0d].d batch %0d expected %h got %h",
                 i, out_cnt, exp_r.d, got[i].d);
        err_cnt++;
      end
    end
  endtask

  // ========================================
  // port monitor
  // ========================================
  always @(posedge clk) begin
    if (reset) begin
      // both outputs must be quiet while reset is held
      if (in_credit === 1'b1 || out_valid === 1'b1) begin
        $display("in_credit or out_valid went high while reset was held");
        err_cnt++;
      end
    end else begin
      if (in_valid) begin
        pending.push_back(in_data);
        in_cnt++;
      end
      if (in_credit) begin
        credit_pulses++;
      end
      // spend before adding, a credit seen this edge pays for a later beat
      if (out_valid) begin
        if (granted == 0) begin
          $display("out_valid appeared without a granted downstream credit");
          err_cnt++;
        end else begin
          granted--;
        end
        if (pending.size() == 0) begin
          $display("output batch appeared with no batch pending");
          err_cnt++;
        end else begin
          compare_batch(pending.pop_front(), out_data);
        end
        out_cnt++;
      end
      if (out_credit) begin
        granted++;
      end
      if (totals_req && !done_flag) begin
        if (credit_pulses != in_cnt) begin
          $display("CHECK FAILED in_credit pulses expected %h got %h", in_cnt, credit_pulses);
          err_cnt++;
        end
        if (out_cnt != in_cnt) begin
          $display("CHECK FAILED out_valid count expected %h got %h", in_cnt, out_cnt);
          err_cnt++;
        end
        done_flag = 1'b1;
      end
    end
  end

endmodule

// ==== testbench/tb_fft_stage.sv ====
// 12 batches, rows 2 and 3 hold back out_credit for 30 cycles; inputs change on the falling edge
module tb_fft_stage;
  import fft_pkg::*;

  localparam int NUM_ROWS = 12;
  localparam int RESET_CYCLES = 8;
  localparam int STALL_CYCLES = 30;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (BATCH + 40) + 200;

  logic       clk;
  logic       reset;
  logic       in_valid;
  batch_in_t  in_data;
  logic       in_credit;
  logic       out_valid;
  batch_out_t out_data;
  logic       out_credit;
  logic       totals_req;

  int   chk_errors;
  int   in_count;
  int   out_count;
  logic totals_done;

  // stimulus table, one batch and one stall flag per row
  batch_in_t stim [NUM_ROWS];
  logic      stall [NUM_ROWS];

  int unsigned lcg_state = 48;
  int cycles = 0;
  int proto_errors = 0;
  // upstream credit model, level = IN_DEPTH + gained - spent
  int credits_gained = 0;
  int credits_spent = 0;

  fft_stage_top DUT (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_credit(out_credit)
  );

  fft_stage_checker chk (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_credit (out_credit),
    .totals_req (totals_req),
    .errors     (chk_errors),
    .in_count   (in_count),
    .out_count  (out_count),
    .totals_done(totals_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================
  // stimulus helpers
  // ========================================
  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // uniform in -8192 .. 8192
  function automatic int next_operand();
    lcg_state = lcg_next(lcg_state);
    return int'((lcg_state >> 16) % 16385) - 8192;
  endfunction

  function automatic bfly_pair_t make_pair(input int ar, input int ai, input int br,
                                           input int bi, input logic [1:0] k);
    bfly_pair_t p;
    p.a.re = WIDTH'(ar);
    p.a.im = WIDTH'(ai);
    p.b.re = WIDTH'(br);
    p.b.im = WIDTH'(bi);
    p.k = k;
    return p;
  endfunction

  task automatic fill_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      stall[r] = 1'b0;
    end
    // k = 0 rows, plain add and subtract with wrap at the rails
    stim[0][0] = make_pair(100, -200, 300, 400, 2'd0);
    stim[0][1] = make_pair(32767, 0, 1, 0, 2'd0);
    stim[0][2] = make_pair(-32768, 5, 0, -1, 2'd0);
    stim[0][3] = make_pair(0, -32768, 0, 1, 2'd0);
    stim[1][0] = make_pair(1234, -4321, -8192, 8191, 2'd0);
    stim[1][1] = make_pair(-1, -1, -1, -1, 2'd0);
    stim[1][2] = make_pair(16384, -16384, 16384, 16384, 2'd0);
    stim[1][3] = make_pair(0, 0, 0, 0, 2'd0);
    // mixed twiddles, these two rows also stall downstream
    stim[2][0] = make_pair(1000, 2000, 4096, -4096, 2'd1);
    stim[2][1] = make_pair(-3000, 500, 8192, 1, 2'd2);
    stim[2][2] = make_pair(7, -7, -8192, -8192, 2'd3);
    stim[2][3] = make_pair(0, 0, -1, 1, 2'd1);
    stim[3][0] = make_pair(8191, 8191, 8191, -8191, 2'd3);
    stim[3][1] = make_pair(-8192, 0, -8192, -8192, 2'd2);
    stim[3][2] = make_pair(123, 456, -789, 1011, 2'd1);
    stim[3][3] = make_pair(-5, 5, 2, -2, 2'd0);
    stall[2] = 1'b1;
    stall[3] = 1'b1;
    // random rows, back to back
    for (int r = 4; r < NUM_ROWS; r++) begin
      for (int i = 0; i < BATCH; i++) begin
        stim[r][i] = make_pair(next_operand(), next_operand(), next_operand(),
                               next_operand(), 2'(next_operand()));
      end
    end
  endtask

  // ========================================
  // upstream and downstream models
  // ========================================
  task automatic send_batches();
    for (int r = 0; r < NUM_ROWS; r++) begin
      while (IN_DEPTH + credits_gained - credits_spent <= 0) begin
        @(negedge clk);
      end
      in_valid = 1'b1;
      in_data = stim[r];
      credits_spent++;
      @(negedge clk);
      in_valid = 1'b0;
    end
    in_data = '0;
  endtask

  // keeps at most OUT_DEPTH + 1 credits outstanding at the sender
  task automatic return_credits();
    for (int r = 0; r < NUM_ROWS; r++) begin
      while (out_count + OUT_DEPTH < r) begin
        @(negedge clk);
      end
      if (stall[r]) begin
        repeat (STALL_CYCLES) @(negedge clk);
      end
      out_credit = 1'b1;
      @(negedge clk);
      out_credit = 1'b0;
    end
  endtask

  // credit returns, upstream credit range, run limit
  always @(posedge clk) begin
    int level;
    cycles++;
    if (!reset && in_credit) begin
      credits_gained++;
    end
    level = IN_DEPTH + credits_gained - credits_spent;
    if (level < 0 || level > IN_DEPTH) begin
      $display("upstream credit count left its range, now %0d", level);
      proto_errors++;
    end
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_credit = 1'b0;
    totals_req = 1'b0;
    fill_table();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    fork
      send_batches();
      return_credits();
    join
    while (out_count < NUM_ROWS) begin
      @(negedge clk);
    end
    // let the last credit pulse settle before totals
    repeat (4) @(negedge clk);
    totals_req = 1'b1;
    while (!totals_done) begin
      @(negedge clk);
    end
    $display("errors: checker %0d, protocol %0d; batches in %0d, out %0d",
             chk_errors, proto_errors, in_count, out_count);
    if (chk_errors + proto_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
